// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;     // Instruction, immediate or APB data
    typedef logic [4:0]  reg_id_t;
    typedef logic [3:0]  apb_addr_t;
    typedef logic [2:0]  q_count_t;  // Occupancy 0 to 4

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [QUEUE_PTR_W-1:0] q_ptr_t;

    // APB register map
    localparam apb_addr_t ADDR_PUSH      = 4'h0;  // Push, predict 0
    localparam apb_addr_t ADDR_PUSH_PRED = 4'h4;  // Push, predict 1
    localparam apb_addr_t ADDR_STATUS    = 4'h8;  // Read only occupancy

    //////////////////////////////////////////////////
    // Opcodes and funct7 classes
    //////////////////////////////////////////////////

    localparam logic [6:0] OP_LUI    = 7'b011_0111;
    localparam logic [6:0] OP_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OP_JAL    = 7'b110_1111;
    localparam logic [6:0] OP_JALR   = 7'b110_0111;
    localparam logic [6:0] OP_BRANCH = 7'b110_0011;
    localparam logic [6:0] OP_LOAD   = 7'b000_0011;
    localparam logic [6:0] OP_STORE  = 7'b010_0011;
    localparam logic [6:0] OP_ALU    = 7'b011_0011;
    localparam logic [6:0] OP_ALUI   = 7'b001_0011;

    localparam logic [6:0] F7_BASE   = 7'b000_0000;
    localparam logic [6:0] F7_ALT    = 7'b010_0000;  // SUB and SRA
    localparam logic [6:0] F7_MULDIV = 7'b000_0001;  // M extension

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } encoding_type;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS
    } alu_op_type;

    //////////////////////////////////////////////////
    // Pipeline bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_id_t    rs2;
        reg_id_t    rs1;
        logic [2:0] funct3;
        reg_id_t    rd;
        logic [6:0] opcode;
    } instruction_type;

    typedef struct packed {
        instruction_type instruction;
        logic            predict;
        logic            instr_valid;
    } if_id_type;

    typedef struct packed {
        encoding_type encoding;
        alu_op_type   alu_op;
        logic [2:0]   funct3;
        reg_id_t      rs1_id;
        reg_id_t      rs2_id;
        reg_id_t      rd_id;
        logic         rs1_valid;
        logic         rs2_valid;
        logic         reg_write;
        logic         alu_src;      // Second operand is the immediate
        logic         mem_read;
        logic         mem_write;
        logic         mem_to_reg;
        logic         is_branch;
        logic         is_jump;
        logic         is_jumpr;
        logic         is_lui;
        logic         is_auipc;
        logic         is_mul;
        logic         predict;
        logic         is_valid;
        word_t        imm_data;
    } control_type;

    // Sign extended immediate for each instruction format
    function automatic word_t immediate_extension(input instruction_type instr,
                                                  input encoding_type    enc);
        word_t imm;
        case (enc)
            I_TYPE: imm = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2};
            S_TYPE: imm = {{20{instr.funct7[6]}}, instr.funct7, instr.rd};
            B_TYPE: imm = {{20{instr.funct7[6]}}, instr.rd[0], instr.funct7[5:0],
                           instr.rd[4:1], 1'b0};
            U_TYPE: imm = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'h000};
            J_TYPE: imm = {{12{instr.funct7[6]}}, instr.rs1, instr.funct3, instr.rs2[0],
                           instr.funct7[5:0], instr.rs2[4:1], 1'b0};
            default: imm = '0;  // R type has no immediate
        endcase
        return imm;
    endfunction

endpackage

`default_nettype wire

// ==== common/instr_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One fetched instruction per transfer, valid and ready handshake
interface instr_stream_if;

    logic                    valid;
    logic                    ready;
    rv_pkg::instruction_type instr;
    logic                    predict;  // Branch prediction bit from the host

    // Side that pushes entries into the stream
    modport push (output valid, output instr, output predict, input ready);

    // Side that pops entries from the stream
    modport pop (input valid, input instr, input predict, output ready);

endinterface

`default_nettype wire

// ==== source/apb_instr_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_instr_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  rv_pkg::apb_addr_t paddr,
    input  rv_pkg::word_t     pwdata,
    input  rv_pkg::q_count_t  count,
    output rv_pkg::word_t     prdata,
    output logic              pready,
    output logic              pslverr,
    instr_stream_if.push      push
);

    logic access_done;  // Access already completed, waiting for penable to drop
    logic access;
    logic is_push_addr;
    logic is_status_addr;
    logic wr_push;
    logic legal;

    assign access         = psel & penable & ~access_done;
    assign is_push_addr   = (paddr == rv_pkg::ADDR_PUSH) || (paddr == rv_pkg::ADDR_PUSH_PRED);
    assign is_status_addr = (paddr == rv_pkg::ADDR_STATUS);

    // Writes go to push addresses, reads to STATUS
    assign legal   = (pwrite & is_push_addr) | (~pwrite & is_status_addr);
    assign wr_push = access & pwrite & is_push_addr;

    assign push.valid   = wr_push;
    assign push.instr   = pwdata;
    assign push.predict = (paddr == rv_pkg::ADDR_PUSH_PRED);

    // Wait states only while a push is refused
    assign pready  = wr_push ? push.ready : 1'b1;
    assign pslverr = access & ~legal;
    assign prdata  = (access & ~pwrite & is_status_addr) ? rv_pkg::word_t'(count) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            access_done <= 1'b0;
        end else if (~psel | ~penable) begin
            access_done <= 1'b0;  // Back to setup or idle
        end else if (access & pready) begin
            access_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== decode/instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

// The queue pops the APB stream and pushes the decode stream
module instr_queue (
    input  logic             clk,
    input  logic             rst,
    instr_stream_if.pop      push,  // Write side
    instr_stream_if.push     pop,   // Read side
    output rv_pkg::q_count_t count
);

    rv_pkg::instruction_type instr_mem [rv_pkg::QUEUE_DEPTH];
    logic                    pred_mem  [rv_pkg::QUEUE_DEPTH];
    rv_pkg::q_ptr_t          wr_ptr;
    rv_pkg::q_ptr_t          rd_ptr;
    logic                    wr_en;
    logic                    rd_en;

    function automatic rv_pkg::q_ptr_t next_ptr(input rv_pkg::q_ptr_t ptr);
        if (ptr == rv_pkg::q_ptr_t'(rv_pkg::QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push.ready  = (count != rv_pkg::q_count_t'(rv_pkg::QUEUE_DEPTH));  // Not full
    assign pop.valid   = (count != '0);                                      // Not empty
    assign pop.instr   = instr_mem[rd_ptr];
    assign pop.predict = pred_mem[rd_ptr];

    assign wr_en = push.valid & push.ready;
    assign rd_en = pop.valid & pop.ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            instr_mem[wr_ptr] <= push.instr;
            pred_mem[wr_ptr]  <= push.predict;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decode/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  rv_pkg::if_id_type   if_instr,
    output rv_pkg::control_type control
);

    rv_pkg::instruction_type instr;

    assign instr = if_instr.instruction;

    // ALU operation for OP and OP-IMM
    function automatic rv_pkg::alu_op_type alu_arith(input logic [6:0] funct7,
                                                     input logic [2:0] funct3,
                                                     input logic       imm);
        logic base;
        logic alt;
        rv_pkg::alu_op_type op;
        base = (funct7 == rv_pkg::F7_BASE);
        alt  = (funct7 == rv_pkg::F7_ALT);
        op   = rv_pkg::ALU_ADD;
        case (funct3)
            3'b000: if (~imm & alt) op = rv_pkg::ALU_SUB;  // No SUBI
            3'b001: if (base) op = rv_pkg::ALU_SLL;
            3'b010: if (imm | base) op = rv_pkg::ALU_SLT;
            3'b011: if (imm | base) op = rv_pkg::ALU_SLTU;
            3'b100: if (imm | base) op = rv_pkg::ALU_XOR;
            3'b101: begin
                if (base) op = rv_pkg::ALU_SRL;
                else if (alt) op = rv_pkg::ALU_SRA;
            end
            3'b110: if (imm | base) op = rv_pkg::ALU_OR;
            default: if (imm | base) op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////

    always_comb begin
        control           = '0;
        control.funct3    = instr.funct3;
        control.rs1_id    = instr.rs1;
        control.rs2_id    = instr.rs2;
        control.rd_id     = instr.rd;
        control.rs1_valid = 1'b1;
        control.rs2_valid = 1'b1;
        control.predict   = if_instr.predict;
        control.is_valid  = if_instr.instr_valid;

        case (instr.opcode)
            rv_pkg::OP_LUI: begin
                control.encoding  = rv_pkg::U_TYPE;
                control.alu_op    = rv_pkg::ALU_PASS;  // rd = imm
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
                control.is_lui    = 1'b1;
                control.rs1_valid = 1'b0;
                control.rs2_valid = 1'b0;
            end
            rv_pkg::OP_AUIPC: begin
                control.encoding  = rv_pkg::U_TYPE;
                control.alu_op    = rv_pkg::ALU_ADD;
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
                control.is_auipc  = 1'b1;
                control.rs1_valid = 1'b0;
                control.rs2_valid = 1'b0;
            end
            rv_pkg::OP_JAL: begin
                control.encoding  = rv_pkg::J_TYPE;
                control.alu_op    = rv_pkg::ALU_ADD;
                control.reg_write = 1'b1;
                control.is_jump   = 1'b1;
                control.rs1_valid = 1'b0;
                control.rs2_valid = 1'b0;
            end
            rv_pkg::OP_JALR: begin
                control.encoding  = rv_pkg::I_TYPE;
                control.alu_op    = rv_pkg::ALU_ADD;  // rs1 + offset
                control.reg_write = 1'b1;
                control.is_jumpr  = 1'b1;
                control.rs2_valid = 1'b0;
            end
            rv_pkg::OP_BRANCH: begin
                control.encoding  = rv_pkg::B_TYPE;
                control.alu_op    = rv_pkg::ALU_SUB;  // Compare by subtraction
                control.is_branch = 1'b1;
            end
            rv_pkg::OP_LOAD: begin
                control.encoding   = rv_pkg::I_TYPE;
                control.alu_op     = rv_pkg::ALU_ADD;
                control.reg_write  = 1'b1;
                control.alu_src    = 1'b1;
                control.mem_read   = 1'b1;
                control.mem_to_reg = 1'b1;
                control.rs2_valid  = 1'b0;
            end
            rv_pkg::OP_STORE: begin
                control.encoding  = rv_pkg::S_TYPE;
                control.alu_op    = rv_pkg::ALU_ADD;
                control.alu_src   = 1'b1;
                control.mem_write = 1'b1;
            end
            rv_pkg::OP_ALUI: begin
                control.encoding  = rv_pkg::I_TYPE;
                control.alu_op    = alu_arith(instr.funct7, instr.funct3, 1'b1);
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
                control.rs2_valid = 1'b0;
            end
            rv_pkg::OP_ALU: begin
                control.encoding  = rv_pkg::R_TYPE;
                control.alu_op    = alu_arith(instr.funct7, instr.funct3, 1'b0);
                control.reg_write = 1'b1;
                control.is_mul    = (instr.funct7 == rv_pkg::F7_MULDIV);
            end
            default: control = '0;  // Unknown opcode, empty bundle
        endcase

        control.imm_data = rv_pkg::immediate_extension(instr, control.encoding);
        if (instr.rd == '0) begin
            control.reg_write = 1'b0;  // x0 is never written
        end
    end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    instr_stream_if.pop         pop,
    output logic                dec_valid,
    output rv_pkg::control_type dec_control,
    input  logic                dec_ready
);

    rv_pkg::if_id_type   if_instr;
    rv_pkg::control_type control;
    logic                load;
    logic                pop_fire;

    // Output register free or draining this cycle
    assign load      = ~dec_valid | dec_ready;
    assign pop.ready = load;
    assign pop_fire  = pop.valid & pop.ready;

    assign if_instr = {pop.instr, pop.predict, pop_fire};

    control_unit control_unit_inst (
        .if_instr (if_instr),
        .control  (control)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= pop.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_fire) dec_control <= control;  // Held under back-pressure
    end

endmodule

`default_nettype wire

// ==== source/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  rv_pkg::apb_addr_t   paddr,
    input  rv_pkg::word_t       pwdata,
    output rv_pkg::word_t       prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                dec_valid,
    input  logic                dec_ready,
    output rv_pkg::control_type dec_control
);

    rv_pkg::q_count_t q_count;

    instr_stream_if apb_stream ();  // APB port to queue
    instr_stream_if dec_stream ();  // Queue to decode

    apb_instr_port apb_instr_port_inst (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .count   (q_count),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .push    (apb_stream.push)
    );

    instr_queue instr_queue_inst (
        .clk   (clk),
        .rst   (rst),
        .push  (apb_stream.pop),
        .pop   (dec_stream.push),
        .count (q_count)
    );

    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .pop         (dec_stream.pop),
        .dec_valid   (dec_valid),
        .dec_control (dec_control),
        .dec_ready   (dec_ready)
    );

endmodule

`default_nettype wire

// ==== sim/tb_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    logic                clk = 1'b0;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    rv_pkg::apb_addr_t   paddr;
    rv_pkg::word_t       pwdata;
    rv_pkg::word_t       prdata;
    logic                pready;
    logic                pslverr;
    logic                dec_valid;
    logic                dec_ready;
    rv_pkg::control_type dec_control;

    int                  seed = 32168;
    rv_pkg::control_type exp_q [$];  // Bundles still expected at the output, in order

    always #5 clk = ~clk;

    decode_top decode_top_inst (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_control (dec_control)
    );

    //////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_control(input rv_pkg::control_type got, input rv_pkg::control_type exp,
                                 input string name);
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            report_failure("decoded bundle mismatch");
        end
    endtask

    task automatic check_word(input rv_pkg::word_t got, input rv_pkg::word_t exp,
                              input string name);
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            report_failure("data word mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("error: %s expected %h got %h", name, exp, got);
            report_failure("status flag mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Reference decoder
    //////////////////////////////////////////////////

    // Legal OP and OP-IMM encodings only
    function automatic rv_pkg::alu_op_type reference_alu_op(input rv_pkg::word_t w,
                                                            input logic is_imm);
        if (!is_imm && w[31:25] == 7'h01) begin
            return rv_pkg::ALU_ADD;  // M extension rides on the ADD slot
        end
        case (w[14:12])
            3'd0: return (!is_imm && w[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'd1: return rv_pkg::ALU_SLL;
            3'd2: return rv_pkg::ALU_SLT;
            3'd3: return rv_pkg::ALU_SLTU;
            3'd4: return rv_pkg::ALU_XOR;
            3'd5: return w[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'd6: return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    function automatic rv_pkg::control_type expected_control(input rv_pkg::word_t w,
                                                             input logic pred);
        rv_pkg::control_type c;
        logic [6:0]          op;
        op = w[6:0];
        c = '0;
        case (op)
            7'h37, 7'h17: c.encoding = rv_pkg::U_TYPE;
            7'h6F: c.encoding = rv_pkg::J_TYPE;
            7'h67, 7'h03, 7'h13: c.encoding = rv_pkg::I_TYPE;
            7'h63: c.encoding = rv_pkg::B_TYPE;
            7'h23: c.encoding = rv_pkg::S_TYPE;
            7'h33: c.encoding = rv_pkg::R_TYPE;
            default: return '0;  // Unknown opcode
        endcase
        c.funct3     = w[14:12];
        c.rs1_id     = w[19:15];
        c.rs2_id     = w[24:20];
        c.rd_id      = w[11:7];
        c.predict    = pred;
        c.is_valid   = 1'b1;
        c.rs1_valid  = (c.encoding != rv_pkg::U_TYPE) && (c.encoding != rv_pkg::J_TYPE);
        c.rs2_valid  = (c.encoding == rv_pkg::R_TYPE) || (c.encoding == rv_pkg::S_TYPE) ||
                       (c.encoding == rv_pkg::B_TYPE);
        c.alu_src    = (op == 7'h37) || (op == 7'h17) || (op == 7'h03) || (op == 7'h23) ||
                       (op == 7'h13);
        c.reg_write  = (op != 7'h63) && (op != 7'h23) && (w[11:7] != 5'd0);
        c.mem_read   = (op == 7'h03);
        c.mem_to_reg = (op == 7'h03);
        c.mem_write  = (op == 7'h23);
        c.is_branch  = (op == 7'h63);
        c.is_jump    = (op == 7'h6F);
        c.is_jumpr   = (op == 7'h67);
        c.is_lui     = (op == 7'h37);
        c.is_auipc   = (op == 7'h17);
        c.is_mul     = (op == 7'h33) && (w[31:25] == 7'h01);
        case (op)
            7'h37: c.alu_op = rv_pkg::ALU_PASS;
            7'h63: c.alu_op = rv_pkg::ALU_SUB;
            7'h33: c.alu_op = reference_alu_op(w, 1'b0);
            7'h13: c.alu_op = reference_alu_op(w, 1'b1);
            default: c.alu_op = rv_pkg::ALU_ADD;
        endcase
        case (c.encoding)
            rv_pkg::I_TYPE: c.imm_data = {{20{w[31]}}, w[31:20]};
            rv_pkg::S_TYPE: c.imm_data = {{20{w[31]}}, w[31:25], w[11:7]};
            rv_pkg::B_TYPE: c.imm_data = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_pkg::U_TYPE: c.imm_data = {w[31:12], 12'h000};
            rv_pkg::J_TYPE: c.imm_data = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: c.imm_data = '0;
        endcase
        return c;
    endfunction

    // Random legal instruction from one of the nine opcode classes
    function automatic rv_pkg::word_t random_instr();
        rv_pkg::word_t w;
        int            kind;
        w = $random(seed);
        kind = {$random(seed)} % 9;
        case (kind)
            0: w[6:0] = 7'h37;
            1: w[6:0] = 7'h17;
            2: w[6:0] = 7'h6F;
            3: begin
                w[6:0]   = 7'h67;
                w[14:12] = 3'd0;
            end
            4: w[6:0] = 7'h63;
            5: w[6:0] = 7'h03;
            6: w[6:0] = 7'h23;
            7: begin
                w[6:0] = 7'h13;
                if (w[14:12] == 3'd1) w[31:25] = 7'h00;
                else if (w[14:12] == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
            end
            default: begin
                w[6:0]   = 7'h33;
                w[31:25] = w[25] ? 7'h01 :
                           ((w[26] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00);
            end
        endcase
        return w;
    endfunction

    //////////////////////////////////////////////////
    // APB and output side
    //////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input rv_pkg::apb_addr_t addr,
                              input rv_pkg::word_t data, output rv_pkg::word_t rdata,
                              output logic err);
        int cycles;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!pready) begin  // Wait states
            cycles++;
            if (cycles > 100) report_failure("timeout waiting for pready");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input rv_pkg::apb_addr_t addr, input rv_pkg::word_t data,
                             output logic err);
        rv_pkg::word_t unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input rv_pkg::apb_addr_t addr, output rv_pkg::word_t data,
                            output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_decoded();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!dec_valid) begin
            cycles++;
            if (cycles > 100) report_failure("timeout waiting for dec_valid");
            @(negedge clk);
        end
    endtask

    // One output transfer, compared with the oldest expected bundle
    task automatic take_decoded();
        wait_decoded();
        if (exp_q.size() == 0) report_failure("decoded output appeared with nothing pending");
        check_control(dec_control, exp_q.pop_front(), "dec_control");
    endtask

    task automatic push_instr(input rv_pkg::word_t w, input logic pred);
        logic err;
        exp_q.push_back(expected_control(w, pred));
        apb_write(pred ? rv_pkg::ADDR_PUSH_PRED : rv_pkg::ADDR_PUSH, w, err);
        check_flag(err, 1'b0, "pslverr");
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    // Every opcode class, immediates of both signs, x0 and unknown opcodes
    task automatic directed_decode();
        rv_pkg::word_t words [46];
        words = '{
            32'h123452B7, 32'hFFFFF337, 32'h80000397,                          // LUI, AUIPC
            32'hFFDFF0EF, 32'h0100006F, 32'h00C100E7, 32'hFF8100E7,            // JAL, JALR
            32'h00208463, 32'hFE4198E3, 32'h0020C463, 32'h0020D463,
            32'h0020E463, 32'h0020F463,                                        // Branches
            32'h00430283, 32'h00431283, 32'hFFC32283, 32'h00434283,
            32'h00435283,                                                      // Loads
            32'h00530423, 32'h00531423, 32'hFE532A23,                          // Stores
            32'hFFF10093, 32'h00522193, 32'h00523193, 32'h00524193, 32'h00526193,
            32'h00527193, 32'h00311093, 32'h00315093, 32'h40315093,            // OP-IMM
            32'h002081B3, 32'h402081B3, 32'h002091B3, 32'h0020A1B3, 32'h0020B1B3,
            32'h0020C1B3, 32'h0020D1B3, 32'h4020D1B3, 32'h0020E1B3, 32'h0020F1B3,
            32'h022081B3, 32'h0220C1B3, 32'h0220F1B3,                          // M extension
            32'h00000013, 32'hFFFFFFFF, 32'h0000000B                           // x0, unknown
        };
        for (int i = 0; i < 46; i++) begin
            push_instr(words[i], i[0]);  // Alternate both push addresses
            take_decoded();
        end
    endtask

    task automatic random_stream();
        rv_pkg::word_t words [40];
        rv_pkg::word_t rnd;
        logic          preds [40];
        for (int i = 0; i < 40; i++) begin
            words[i] = random_instr();
            rnd      = $random(seed);
            preds[i] = rnd[0];
        end
        fork
            for (int i = 0; i < 40; i++) begin
                push_instr(words[i], preds[i]);
            end
            repeat (40) take_decoded();
        join
    endtask

    task automatic backpressure_status();
        rv_pkg::word_t words [6];
        rv_pkg::word_t status;
        logic          err;
        logic          last_err;
        @(posedge clk);
        dec_ready <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            words[i] = random_instr();
        end
        for (int i = 0; i < 5; i++) begin
            push_instr(words[i], 1'b0);
        end
        apb_read(rv_pkg::ADDR_STATUS, status, err);
        check_flag(err, 1'b0, "pslverr");
        check_word(status, 32'd4, "prdata");  // Decode register not counted
        exp_q.push_back(expected_control(words[5], 1'b0));
        fork
            apb_write(rv_pkg::ADDR_PUSH, words[5], last_err);
            begin
                repeat (3) @(posedge clk);
                repeat (4) begin
                    @(negedge clk);
                    check_flag(pready, 1'b0, "pready");
                    check_flag(dec_valid, 1'b1, "dec_valid");
                    check_control(dec_control, exp_q[0], "dec_control");  // Held
                end
                @(posedge clk);
                dec_ready <= 1'b1;
                repeat (6) take_decoded();
            end
        join
        check_flag(last_err, 1'b0, "pslverr");
    endtask

    task automatic apb_error_access();
        rv_pkg::word_t data;
        logic          err;
        @(posedge clk);
        dec_ready <= 1'b0;  // Any stray push stays in the decode register
        apb_read(rv_pkg::ADDR_PUSH, data, err);
        check_flag(err, 1'b1, "pslverr");
        apb_read(rv_pkg::ADDR_PUSH_PRED, data, err);
        check_flag(err, 1'b1, "pslverr");
        apb_write(rv_pkg::ADDR_STATUS, 32'h00000013, err);
        check_flag(err, 1'b1, "pslverr");
        apb_write(4'hC, 32'h00000013, err);  // Unmapped
        check_flag(err, 1'b1, "pslverr");
        apb_read(4'h2, data, err);
        check_flag(err, 1'b1, "pslverr");
        repeat (4) begin
            @(negedge clk);
            check_flag(dec_valid, 1'b0, "dec_valid");
        end
        apb_read(rv_pkg::ADDR_STATUS, data, err);
        check_flag(err, 1'b0, "pslverr");
        check_word(data, 32'd0, "prdata");
    endtask

    initial begin
        rst       <= 1'b1;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        dec_ready <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(dec_valid, 1'b0, "dec_valid");
        check_flag(pready, 1'b1, "pready");
        check_flag(pslverr, 1'b0, "pslverr");

        directed_decode();
        random_stream();
        backpressure_status();
        apb_error_access();

        if (exp_q.size() != 0) begin
            report_failure("expected decoded outputs never appeared");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/rv_pkg.sv
common/instr_stream_if.sv
source/apb_instr_port.sv
decode/instr_queue.sv
decode/control_unit.sv
decode/decode_stage.sv
source/decode_top.sv
sim/tb_decode_top.sv
